// File: sim.f
+incdir+source
source/stream_pkg.sv
source/udp_pkg.sv
source/udp_stream_if.sv
source/udp_rx_filter.sv
source/echo_fifo.sv
source/udp_tx_output.sv
source/udp_echo_top.sv
verification/udp_echo_assertions.sv
verification/udp_echo_tb.sv

// File: Bender.yml
package:
  name: udp_echo

export_include_dirs:
  - source

sources:
  - files:
      - source/stream_pkg.sv
      - source/udp_pkg.sv
      - source/udp_stream_if.sv
      - source/udp_rx_filter.sv
      - source/echo_fifo.sv
      - source/udp_tx_output.sv
      - source/udp_echo_top.sv
  - target: simulation
    files:
      - verification/udp_echo_assertions.sv
      - verification/udp_echo_tb.sv

// File: verification/udp_echo_tb.sv
// random-stimulus testbench for udp_echo_top, replies and led checked against a reference model
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_echo_tb;
    import stream_pkg::*;
    import udp_pkg::*;

    // cycles any single wait may take
    localparam int TIMEOUT = 1000;

    logic       clk;
    logic       rst;
    data_t      rx_data;
    keep_t      rx_keep;
    logic       rx_valid;
    logic       rx_ready;
    logic       rx_last;
    data_t      tx_data;
    keep_t      tx_keep;
    logic       tx_valid;
    logic       tx_ready;
    logic       tx_last;
    logic [7:0] led;

    // tx_ready held low until the fifo backs up into rx
    bit hold_tx;
    // set once rx_ready was seen low on an echo frame
    bit saw_full;

    // beats of the frame being sent
    beat_t frame_q[$];
    // reply beats still owed on tx, in order
    beat_t exp_q[$];

    udp_echo_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("TEST FAIL");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t: %s is %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic report_error(input string why);
        $display("error at time %0t: %s", $time, why);
        end_with_failure();
    endtask

    // inputs move on falling edges, tx_ready redrawn each cycle
    task automatic next_cycle();
        @(negedge clk);
        if (hold_tx) begin
            tx_ready = 1'b0;
        end else begin
            tx_ready = ($urandom_range(0, 1) == 1);
        end
    endtask

    // hold one beat on rx until it is taken
    task automatic send_beat(input beat_t b, input bit dropped);
        int waited;
        rx_data  = b.data;
        rx_keep  = b.keep;
        rx_last  = b.last;
        rx_valid = 1'b1;
        waited   = 0;
        @(posedge clk);
        if (dropped) begin
            check_value("rx_ready on a dropped frame", rx_ready, 1);
        end
        while (!rx_ready) begin
            // fifo is full, let tx drain from here on
            saw_full = 1'b1;
            hold_tx  = 1'b0;
            waited++;
            if (waited > TIMEOUT) begin
                report_error("rx_ready stayed low, the input stream is stuck");
            end
            next_cycle();
            @(posedge clk);
        end
        next_cycle();
        rx_valid = 1'b0;
    endtask

    // reference model: echo port gets swapped ports and zero checksum, others vanish
    function automatic void add_expected();
        udp_header_t h;
        beat_t       b;
        h = frame_q[0].data;
        if (h.dst_port != port_t'(`UDP_ECHO_PORT)) begin
            return;
        end
        b      = frame_q[0];
        b.data = {h.dst_port, h.src_port, h.length, 16'h0000};
        exp_q.push_back(b);
        for (int i = 1; i < frame_q.size(); i++) begin
            exp_q.push_back(frame_q[i]);
        end
    endfunction

    // stop on the first failed bound assertion
    initial begin
        forever begin
            @(negedge clk);
            if (u_dut.u_assertions.fail_count != 0) begin
                report_error("a bound assertion on the DUT ports failed");
            end
        end
    end

    // compare every tx transfer, then led at the end of each reply
    initial begin
        beat_t      e;
        logic [7:0] exp_led;
        bit         at_hdr;
        bit         first_pl;
        exp_led  = 8'h00;
        at_hdr   = 1'b1;
        first_pl = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && tx_valid && tx_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("a beat came out on tx with no echo frame pending");
                end
                e = exp_q.pop_front();
                check_value("tx_data", tx_data, e.data);
                check_value("tx_keep", tx_keep, e.keep);
                check_value("tx_last", tx_last, e.last);
                if (at_hdr) begin
                    first_pl = !e.last;
                end else begin
                    // led takes the top byte of the first payload word
                    if (first_pl) begin
                        exp_led = e.data[63:56];
                    end
                    first_pl = 1'b0;
                end
                at_hdr = e.last;
                if (e.last) begin
                    @(negedge clk);
                    check_value("led", led, exp_led);
                end
            end
        end
    end

    initial begin
        int          frames;
        int          n_pl;
        int          waited;
        bit          echo;
        udp_header_t hdr;
        beat_t       b;
        void'($urandom(32'h748a));
        hold_tx  = 1'b1;
        saw_full = 1'b0;
        rx_data  = '0;
        rx_keep  = '0;
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        tx_ready = 1'b0;
        rst      = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        next_cycle();
        // idle before any input
        check_value("tx_valid after reset", tx_valid, 0);
        check_value("led after reset", led, 0);
        frames = $urandom_range(30, 50);
        for (int f = 0; f < frames; f++) begin
            echo = ($urandom_range(0, 1) == 1);
            n_pl = $urandom_range(0, 6);
            hdr.src_port = port_t'($urandom);
            // non-echo ports stay clear of 1234
            hdr.dst_port = echo ? port_t'(`UDP_ECHO_PORT) :
                                  port_t'(`UDP_ECHO_PORT + 1 + $urandom_range(0, 60000));
            hdr.length   = 16'(8 * (n_pl + 1));
            hdr.checksum = 16'($urandom);
            frame_q.delete();
            b.data = hdr;
            b.keep = '1;
            b.last = (n_pl == 0);
            frame_q.push_back(b);
            for (int i = 1; i <= n_pl; i++) begin
                b.data = {$urandom, $urandom};
                b.last = (i == n_pl);
                // partial last beat, enabled bytes start at the msb
                b.keep = b.last ? keep_t'(8'hff << $urandom_range(0, 7)) : '1;
                frame_q.push_back(b);
            end
            add_expected();
            foreach (frame_q[i]) begin
                // random idle gaps on rx_valid
                while ($urandom_range(0, 3) == 0) begin
                    next_cycle();
                end
                send_beat(frame_q[i], !echo);
            end
        end
        hold_tx = 1'b0;
        waited  = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                report_error("echo replies did not drain from tx");
            end
            next_cycle();
        end
        repeat (2) next_cycle();
        check_value("tx_valid after drain", tx_valid, 0);
        check_value("fifo filled under tx back-pressure", saw_full, 1);
        if (u_dut.u_assertions.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", u_dut.u_assertions.fail_count);
            end_with_failure();
        end
    end

endmodule

// File: verification/udp_echo_assertions.sv
// port-level handshake and reset checks, bound into udp_echo_top during simulation
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_echo_assertions (
    input logic              clk,
    input logic              rst,
    input stream_pkg::data_t rx_data,
    input logic              rx_valid,
    input logic              rx_ready,
    input logic              rx_last,
    input stream_pkg::data_t tx_data,
    input stream_pkg::keep_t tx_keep,
    input logic              tx_valid,
    input logic              tx_ready,
    input logic              tx_last,
    input logic [7:0]        led
);
    import udp_pkg::*;

    // failed assertions so far
    int        fail_count = 0;
    logic      in_frame;
    logic      drop_reg;
    logic      hdr_drop;
    udp_word_u rx_word;

    assign rx_word.raw = rx_data;
    assign hdr_drop    = (rx_word.hdr.dst_port != port_t'(`UDP_ECHO_PORT));

    // own frame tracker, seen from the rx port only
    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            drop_reg <= 1'b0;
        end else if (rx_valid && rx_ready) begin
            in_frame <= !rx_last;
            if (!in_frame) begin
                drop_reg <= hdr_drop;
            end
        end
    end

    // stalled tx beat must not move
    a_tx_stable: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=>
            tx_valid && $stable(tx_data) && $stable(tx_keep) && $stable(tx_last))
        else begin
            $error("tx beat changed while stalled");
            fail_count++;
        end

    // first cycle out of reset is idle
    a_reset_idle: assert property (@(posedge clk)
        rst ##1 !rst |-> !tx_valid && (led == 8'h00))
        else begin
            $error("tx_valid or led not cleared by reset");
            fail_count++;
        end

    // dropped frames drain at full rate
    a_drop_ready: assert property (@(posedge clk) disable iff (rst)
        rx_valid && (in_frame ? drop_reg : hdr_drop) |-> rx_ready)
        else begin
            $error("rx_ready low on a dropped frame");
            fail_count++;
        end

endmodule

bind udp_echo_top udp_echo_assertions u_assertions (.*);

// File: source/udp_echo_top.sv
// top of the UDP echo responder, plain rx/tx stream ports and the led byte
`timescale 1ns/1ps

module udp_echo_top (
    input  logic              clk,
    input  logic              rst,
    // request stream
    input  stream_pkg::data_t rx_data,
    input  stream_pkg::keep_t rx_keep,
    input  logic              rx_valid,
    output logic              rx_ready,
    input  logic              rx_last,
    // reply stream
    output stream_pkg::data_t tx_data,
    output stream_pkg::keep_t tx_keep,
    output logic              tx_valid,
    input  logic              tx_ready,
    output logic              tx_last,
    // first payload byte of the last reply
    output logic [7:0]        led
);

    // filter to fifo
    udp_stream_if filt_s ();
    // fifo to output register
    udp_stream_if fifo_s ();

    udp_rx_filter u_rx_filter (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_keep  (rx_keep),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .rx_last  (rx_last),
        .out      (filt_s.source)
    );

    // default depth from the shared macro
    echo_fifo u_fifo (
        .clk (clk),
        .rst (rst),
        .in  (filt_s.sink),
        .out (fifo_s.source)
    );

    udp_tx_output u_tx_output (
        .clk      (clk),
        .rst      (rst),
        .in       (fifo_s.sink),
        .tx_data  (tx_data),
        .tx_keep  (tx_keep),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_last  (tx_last),
        .led      (led)
    );

endmodule

// File: source/udp_tx_output.sv
// registered tx stage driving the output stream, shows each reply's first payload byte on led
`timescale 1ns/1ps

module udp_tx_output (
    input  logic              clk,
    input  logic              rst,
    udp_stream_if.sink        in,
    output stream_pkg::data_t tx_data,
    output stream_pkg::keep_t tx_keep,
    output logic              tx_valid,
    input  logic              tx_ready,
    output logic              tx_last,
    output logic [7:0]        led
);
    import stream_pkg::*;

    localparam int MSB = $bits(data_t) - 1;

    logic load;
    logic tx_fire;
    // next beat sent is a header
    logic hdr_pos;
    // next beat sent is the first payload beat
    logic first_pos;

    // slot free now or freed by this cycle's transfer
    assign in.ready = !tx_valid || tx_ready;
    assign load     = in.valid && in.ready;
    assign tx_fire  = tx_valid && tx_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (in.ready) begin
            tx_valid <= in.valid;
        end
    end

    // held until the downstream takes it
    always_ff @(posedge clk) begin
        if (load) begin
            tx_data <= in.data.raw;
            tx_keep <= in.keep;
            tx_last <= in.last;
        end
    end

    // frame position and led capture on sent beats
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_pos   <= 1'b1;
            first_pos <= 1'b0;
            led       <= 8'h00;
        end else if (tx_fire) begin
            hdr_pos   <= tx_last;
            // header-only frames never reach a payload position
            first_pos <= hdr_pos && !tx_last;
            if (first_pos) begin
                // first byte on the wire is the top byte
                led <= tx_data[MSB -: 8];
            end
        end
    end

endmodule

// File: source/echo_fifo.sv
// synchronous beat FIFO between the rx filter and the tx output stage, depth 2**ADDR_WIDTH
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module echo_fifo #(
    parameter int ADDR_WIDTH = `UDP_FIFO_ADDR_WIDTH
) (
    input  logic         clk,
    input  logic         rst,
    udp_stream_if.sink   in,
    udp_stream_if.source out
);
    import stream_pkg::*;
    import udp_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    beat_t mem [DEPTH];

    // extra msb tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;
    beat_t               wr_beat;
    beat_t               rd_beat;

    assign empty = (wr_ptr == rd_ptr);
    // same index but wrapped a different number of times
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign in.ready  = !full;
    assign out.valid = !empty;

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    // pack the incoming beat
    assign wr_beat = '{data: in.data.raw, keep: in.keep, last: in.last};

    // head entry read without a register
    // so a beat written on an edge shows right after it
    assign rd_beat  = mem[rd_ptr[ADDR_WIDTH-1:0]];
    assign out.data = udp_word_u'(rd_beat.data);
    assign out.keep = rd_beat.keep;
    assign out.last = rd_beat.last;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: source/udp_rx_filter.sv
// input stage, keeps frames for the echo port with a rewritten header and absorbs the rest
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_rx_filter (
    input  logic                clk,
    input  logic                rst,
    input  stream_pkg::data_t   rx_data,
    input  stream_pkg::keep_t   rx_keep,
    input  logic                rx_valid,
    output logic                rx_ready,
    input  logic                rx_last,
    udp_stream_if.source        out
);
    import stream_pkg::*;
    import udp_pkg::*;

    // high while payload beats of a frame are still expected
    logic      in_frame;
    // echo decision taken on the header beat
    logic      echo_reg;
    logic      is_header;
    logic      hdr_match;
    logic      frame_echo;
    udp_word_u in_word;
    udp_word_u out_word;

    assign in_word.raw = rx_data;
    assign is_header   = !in_frame;

    // compare straight off the header beat
    assign hdr_match  = (in_word.hdr.dst_port == port_t'(`UDP_ECHO_PORT));
    assign frame_echo = is_header ? hdr_match : echo_reg;

    // header rewrite for the reply
    always_comb begin
        out_word = in_word;
        if (is_header) begin
            // swap ports
            out_word.hdr.src_port = in_word.hdr.dst_port;
            out_word.hdr.dst_port = in_word.hdr.src_port;
            // length kept, checksum left out
            out_word.hdr.checksum = 16'h0000;
        end
    end

    // echo beats go to the fifo
    assign out.data  = out_word;
    assign out.keep  = rx_keep;
    assign out.last  = rx_last;
    assign out.valid = rx_valid && frame_echo;

    // dropped frames drain at full rate whatever the fifo does
    assign rx_ready = frame_echo ? out.ready : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            echo_reg <= 1'b0;
        end else if (rx_valid && rx_ready) begin
            // next beat is a header once last goes through
            in_frame <= !rx_last;
            if (is_header) begin
                echo_reg <= hdr_match;
            end
        end
    end

endmodule

// File: source/udp_stream_if.sv
// valid/ready stream bundle for connecting the echo stages inside the design
`timescale 1ns/1ps

interface udp_stream_if;
    import stream_pkg::*;
    import udp_pkg::*;

    // word is read as header or payload by the stage that needs it
    udp_word_u data;
    keep_t     keep;
    logic      valid;
    logic      ready;
    // marks the final beat of a frame
    logic      last;

    // producer side
    modport source (
        output data,
        output keep,
        output valid,
        output last,
        input  ready
    );

    // consumer side
    modport sink (
        input  data,
        input  keep,
        input  valid,
        input  last,
        output ready
    );

endinterface

// File: source/udp_pkg.sv
// UDP header types and the header-or-payload word view, compile after stream_pkg
package udp_pkg;

    // port number, network order
    typedef logic [15:0] port_t;

    // header beat layout
    // src_port sits in the top 16 bits
    typedef struct packed {
        port_t       src_port;
        port_t       dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_header_t;

    // one stream word seen two ways
    // hdr on the first beat of a frame
    // raw on every payload beat
    typedef union packed {
        udp_header_t      hdr;
        stream_pkg::data_t raw;
    } udp_word_u;

endpackage

// File: source/stream_pkg.sv
// stream transport types for the echo path, compile before any module that imports it
`include "udp_echo_defines.svh"

package stream_pkg;

    // one data word of the stream
    typedef logic [`UDP_DATA_WIDTH-1:0] data_t;

    // byte enables, msb is the first byte on the wire
    typedef logic [`UDP_KEEP_WIDTH-1:0] keep_t;

    // fifo entry
    // 64 data + 8 keep + 1 last = 73 bits
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
    } beat_t;

endpackage

// File: source/udp_echo_defines.svh
// fixed protocol widths, echo port and FIFO depth, include wherever a macro is needed
`ifndef UDP_ECHO_DEFINES_SVH
`define UDP_ECHO_DEFINES_SVH

// stream word is one 64-bit beat
`define UDP_DATA_WIDTH 64

// one enable bit per data byte
`define UDP_KEEP_WIDTH 8

// frames sent to this destination port come back
`define UDP_ECHO_PORT 16'd1234

// log2 of the echo FIFO depth
// 4 gives 16 entries
`define UDP_FIFO_ADDR_WIDTH 4

`endif
